/* project.f */
src/zxio_pkg.sv
src/zxuno_reg_if.sv
src/zxuno_regs.sv
src/config_regs.sv
src/coreid.sv
src/kempston_joystick.sv
src/io_read_select.sv
src/zxio_top.sv
sim/zxio_assertions.sv
sim/tb_zxio.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the zxio testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_zxio \
   -Mdir "$BUILD_DIR" -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_zxio" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "Simulation reported failures, see $LOG"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

/* sim/tb_zxio.sv */
`timescale 1ns/10ps

module tb_zxio;

   localparam int MAX_LINES  = 64;
   localparam int LINE_WORDS = 5;

   // Command codes of the golden file
   localparam logic [15:0] CMD_END    = 16'h0;
   localparam logic [15:0] CMD_WRITE  = 16'h1;
   localparam logic [15:0] CMD_READ   = 16'h2;
   localparam logic [15:0] CMD_JOY    = 16'h3;
   localparam logic [15:0] CMD_DEVOPT = 16'h4;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        dout_valid;
   logic [4:0]  joy_n;
   logic [7:0]  dev_options;

   logic [15:0] golden [0:MAX_LINES*LINE_WORDS-1];
   int          num_lines;
   int          cycle_limit = 0;
   int          cycle_count = 0;
   int          error_count;
   int          check_count;
   int          group_errors;
   int          group_checks;
   int          groups_run;
   int          groups_passed;

   zxio_top DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .a           (a),
      .iorq_n      (iorq_n),
      .rd_n        (rd_n),
      .wr_n        (wr_n),
      .din         (din),
      .dout        (dout),
      .dout_valid  (dout_valid),
      .joy_n       (joy_n),
      .dev_options (dev_options)
   );

   always #5 clk = ~clk;

   // Run limit, armed once the golden file is loaded
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Run timed out after %0d cycles", cycle_count);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // -------------------------------------------------------------------
   // Bus cycles, entered and left on a falling edge
   // -------------------------------------------------------------------
   task automatic bus_write(input logic [15:0] port, input logic [7:0] data);
      a      = port;
      din    = data;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      @(posedge clk);
      @(negedge clk);
   endtask

   task automatic bus_read(input logic [15:0] port, input logic [7:0] exp_data,
                           input logic exp_valid);
      a      = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      @(posedge clk);
      @(negedge clk);
      // Mid-cycle, between the two rising edges
      if (dout !== exp_data || dout_valid !== exp_valid) begin
         $display("FAIL %0d ns: port %h expected %h valid %b, got %h valid %b",
                  $time, port, exp_data, exp_valid, dout, dout_valid);
         error_count++;
         group_errors++;
      end
      check_count++;
      group_checks++;
      @(posedge clk);
      @(negedge clk);
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      @(posedge clk);
      @(negedge clk);
   endtask

   // Two synchronizer stages plus margin
   task automatic set_joystick(input logic [4:0] pattern);
      joy_n = pattern;
      repeat (3) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic check_dev_options(input logic [7:0] expected);
      if (dev_options !== expected) begin
         $display("FAIL %0d ns: dev_options expected %h, got %h",
                  $time, expected, dev_options);
         error_count++;
         group_errors++;
      end
      check_count++;
      group_checks++;
   endtask

   function automatic string group_name(input logic [15:0] group);
      case (group)
         16'h1:   return "reset values";
         16'h2:   return "address register";
         16'h3:   return "scratch and device options";
         16'h4:   return "core ID stream";
         16'h5:   return "Kempston joystick";
         16'h6:   return "read priority";
         default: return "unnamed group";
      endcase
   endfunction

   task automatic report_group(input logic [15:0] group);
      if (group_errors == 0) begin
         $display("Group %0d (%s): pass, %0d checks", group, group_name(group),
                  group_checks);
         groups_passed++;
      end else begin
         $display("Group %0d (%s): %0d of %0d checks wrong", group, group_name(group),
                  group_errors, group_checks);
      end
      groups_run++;
      group_errors = 0;
      group_checks = 0;
   endtask

   // -------------------------------------------------------------------
   // Golden file sequencer
   // -------------------------------------------------------------------
   initial begin
      int          i;
      int          base;
      logic [15:0] current_group;

      a      = '0;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      din    = '0;
      joy_n  = '1;
      rst_n  = 1'b0;
      error_count   = 0;
      check_count   = 0;
      group_errors  = 0;
      group_checks  = 0;
      groups_run    = 0;
      groups_passed = 0;

      for (i = 0; i < MAX_LINES * LINE_WORDS; i++) begin
         golden[i] = '0;
      end
      $readmemh("sim/zxio_golden.txt", golden);

      num_lines = 0;
      while (num_lines < MAX_LINES && golden[num_lines * LINE_WORDS + 1] != CMD_END) begin
         num_lines++;
      end
      cycle_limit = 4 * num_lines + 50;

      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      current_group = golden[0];
      for (i = 0; i < num_lines; i++) begin
         base = i * LINE_WORDS;
         if (golden[base] != current_group) begin
            report_group(current_group);
            current_group = golden[base];
         end
         case (golden[base + 1])
            CMD_WRITE:  bus_write(golden[base + 2], golden[base + 3][7:0]);
            CMD_READ:   bus_read(golden[base + 2], golden[base + 3][7:0],
                                 golden[base + 4][0]);
            CMD_JOY:    set_joystick(golden[base + 3][4:0]);
            CMD_DEVOPT: check_dev_options(golden[base + 3][7:0]);
            default: begin
               $display("Unknown command %h in golden entry %0d", golden[base + 1], i);
               error_count++;
               group_errors++;
            end
         endcase
      end

      if (num_lines > 0) begin
         report_group(current_group);
      end else begin
         $display("Golden file holds no commands");
         error_count++;
      end

      $display("Groups passed %0d of %0d, checks %0d, errors %0d",
               groups_passed, groups_run, check_count, error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* sim/zxio_assertions.sv */
`timescale 1ns/10ps

module zxio_assertions (
   input logic clk,
   input logic rst_n,
   input logic iorq_n,
   input logic rd_n,
   input logic regrd,
   input logic regwr,
   input logic regaddr_changed
);

   // Strobes from the write edge detect are single-clock pulses
   regwr_single: assert property (@(posedge clk) disable iff (!rst_n) regwr |=> !regwr)
      else $error("regwr held for more than one clock");

   changed_single: assert property (@(posedge clk) disable iff (!rst_n)
      regaddr_changed |=> !regaddr_changed)
      else $error("regaddr_changed held for more than one clock");

   // One write cycle hits only one port
   strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(regwr && regaddr_changed))
      else $error("regwr and regaddr_changed active together");

   // Read strobe only inside a CPU read cycle
   regrd_in_read: assert property (@(posedge clk) disable iff (!rst_n)
      regrd |-> (!iorq_n && !rd_n))
      else $error("regrd high outside a read cycle");

endmodule

bind zxuno_regs zxio_assertions u_assertions (
   .clk             (clk),
   .rst_n           (rst_n),
   .iorq_n          (iorq_n),
   .rd_n            (rd_n),
   .regrd           (reg_bus.regrd),
   .regwr           (reg_bus.regwr),
   .regaddr_changed (reg_bus.regaddr_changed)
);

/* sim/zxio_golden.txt */
// Columns (hex): group command port data valid
// Commands: 1 write port data, 2 read port expected valid, 3 joystick joy_n,
// 4 check dev_options, 0 end of file
1 2 FC3B 00 1
1 4 0000 00 0
1 1 FC3B FE 0
1 2 FD3B 00 1
1 2 7FFD FF 0
2 1 FC3B 0E 0
2 2 FC3B 0E 1
2 1 FC3B 5A 0
2 2 FC3B 5A 1
3 1 FC3B FE 0
3 1 FD3B A5 0
3 2 FD3B A5 1
3 1 FC3B 0E 0
3 1 FD3B 3C 0
3 2 FD3B 3C 1
3 4 0000 3C 0
3 1 FC3B 40 0
3 1 FD3B 99 0
3 4 0000 3C 0
3 1 FC3B FE 0
3 2 FD3B A5 1
4 1 FC3B FF 0
4 2 FD3B 5A 1
4 2 FD3B 58 1
4 2 FD3B 49 1
4 2 FD3B 4F 1
4 2 FD3B 31 1
4 2 FD3B 00 1
4 2 FD3B 5A 1
4 1 FC3B FF 0
4 2 FD3B 5A 1
5 3 0000 1E 0
5 2 001F 01 1
5 3 0000 0F 0
5 2 A51F 10 1
5 3 0000 00 0
5 2 FF1F 1F 1
5 3 0000 15 0
5 2 3C1F 0A 1
6 1 FC3B FE 0
6 3 0000 1B 0
6 2 121F 04 1
6 2 FC3B FE 1
0 0 0000 00 0

/* src/config_regs.sv */
`timescale 1ns/10ps

module config_regs import zxio_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   zxuno_reg_if.dev reg_bus,
   output io_data_t dout,
   output logic     oe,
   output io_data_t dev_options
);

   io_data_t scratch_q;
   io_data_t devopt_q;
   logic     sel_scratch;
   logic     sel_devopt;

   assign sel_scratch = (reg_bus.addr == REG_SCRATCH);
   assign sel_devopt  = (reg_bus.addr == REG_DEVOPTIONS);

   // -------------------------------------------------------------------
   // Register writes
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scratch_q <= '0;
         devopt_q  <= '0;
      end else if (reg_bus.regwr) begin
         if (sel_scratch) begin
            scratch_q <= reg_bus.wdata;
         end
         if (sel_devopt) begin
            devopt_q <= reg_bus.wdata;
         end
      end
   end

   // Read-back of whichever register is selected
   always_comb begin
      dout = IDLE_DATA;
      if (sel_scratch) begin
         dout = scratch_q;
      end else if (sel_devopt) begin
         dout = devopt_q;
      end
   end

   assign oe = reg_bus.regrd && (sel_scratch || sel_devopt);

   // Enable lines for the rest of the core
   assign dev_options = devopt_q;

endmodule

/* src/coreid.sv */
`timescale 1ns/10ps

module coreid import zxio_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   zxuno_reg_if.dev reg_bus,
   output io_data_t dout,
   output logic     oe
);

   logic [$clog2(COREID_LEN)-1:0] idx_q;
   logic                          id_rd;
   logic                          id_rd_q;
   logic                          rd_done;

   assign id_rd   = reg_bus.regrd && (reg_bus.addr == REG_COREID);
   assign rd_done = id_rd_q && !id_rd;

   // -------------------------------------------------------------------
   // Stream index, moves on once each read has finished
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_rd_q <= 1'b0;
         idx_q   <= '0;
      end else begin
         id_rd_q <= id_rd;
         if (reg_bus.regaddr_changed) begin
            idx_q <= '0;
         end else if (rd_done) begin
            if (idx_q == COREID_LEN - 1) begin
               idx_q <= '0;
            end else begin
               idx_q <= idx_q + 1'b1;
            end
         end
      end
   end

   // Byte 0 sits in the top bits of the string
   assign dout = COREID_STRING[(COREID_LEN - 1 - idx_q) * 8 +: 8];
   assign oe   = id_rd;

endmodule

/* src/io_read_select.sv */
`timescale 1ns/10ps

module io_read_select import zxio_pkg::*; (
   input  io_data_t addr_dout,
   input  logic     addr_oe,
   input  io_data_t joy_dout,
   input  logic     joy_oe,
   input  io_data_t cfg_dout,
   input  logic     cfg_oe,
   input  io_data_t id_dout,
   input  logic     id_oe,
   output io_data_t dout,
   output logic     dout_valid
);

   // Highest priority first
   always_comb begin
      if (addr_oe) begin
         dout = addr_dout;
      end else if (joy_oe) begin
         dout = joy_dout;
      end else if (cfg_oe) begin
         dout = cfg_dout;
      end else if (id_oe) begin
         dout = id_dout;
      end else begin
         dout = IDLE_DATA;
      end
   end

   assign dout_valid = addr_oe || joy_oe || cfg_oe || id_oe;

endmodule

/* src/kempston_joystick.sv */
`timescale 1ns/10ps

module kempston_joystick import zxio_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  io_addr_t  a,
   input  logic      iorq_n,
   input  logic      rd_n,
   input  joy_bits_t joy_n,
   output io_data_t  dout,
   output logic      oe
);

   joy_bits_t joy_meta;
   joy_bits_t joy_sync;

   // Two-stage synchronizer, lines idle high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         joy_meta <= '1;
         joy_sync <= '1;
      end else begin
         joy_meta <= joy_n;
         joy_sync <= joy_meta;
      end
   end

   // Upper address byte is not decoded
   assign oe = !iorq_n && !rd_n && (a[7:0] == KEMPSTON_PORT);

   // Active high buttons in the low five bits
   assign dout = {3'b000, ~joy_sync};

endmodule

/* src/zxio_pkg.sv */
package zxio_pkg;

   // -------------------------------------------------------------------
   // Bus types
   // -------------------------------------------------------------------
   typedef logic [15:0] io_addr_t;
   typedef logic [7:0]  io_data_t;
   typedef logic [7:0]  zxreg_addr_t;

   // Fire, up, down, left, right from MSB to LSB
   typedef logic [4:0]  joy_bits_t;

   // -------------------------------------------------------------------
   // I/O ports and ZX-Uno register numbers
   // -------------------------------------------------------------------
   localparam io_addr_t    ZXUNO_ADDR_PORT = 16'hFC3B;
   localparam io_addr_t    ZXUNO_DATA_PORT = 16'hFD3B;

   // Only the low address byte is decoded
   localparam logic [7:0]  KEMPSTON_PORT   = 8'h1F;

   localparam zxreg_addr_t REG_DEVOPTIONS  = 8'h0E;
   localparam zxreg_addr_t REG_SCRATCH     = 8'hFE;
   localparam zxreg_addr_t REG_COREID      = 8'hFF;

   // Core ID stream, first byte in the top bits
   localparam int                      COREID_LEN    = 6;
   localparam logic [COREID_LEN*8-1:0] COREID_STRING = {"ZXIO1", 8'h00};

   // Floating data bus reads as all ones
   localparam io_data_t    IDLE_DATA       = 8'hFF;

endpackage

/* src/zxio_top.sv */
`timescale 1ns/10ps

module zxio_top import zxio_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  io_addr_t  a,
   input  logic      iorq_n,
   input  logic      rd_n,
   input  logic      wr_n,
   input  io_data_t  din,
   output io_data_t  dout,
   output logic      dout_valid,
   input  joy_bits_t joy_n,
   output io_data_t  dev_options
);

   // -------------------------------------------------------------------
   // Read-back sources
   // -------------------------------------------------------------------
   io_data_t addr_dout;
   logic     addr_oe;
   io_data_t joy_dout;
   logic     joy_oe;
   io_data_t cfg_dout;
   logic     cfg_oe;
   io_data_t id_dout;
   logic     id_oe;

   zxuno_reg_if reg_bus ();

   zxuno_regs u_zxuno_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .iorq_n    (iorq_n),
      .rd_n      (rd_n),
      .wr_n      (wr_n),
      .din       (din),
      .addr_dout (addr_dout),
      .addr_oe   (addr_oe),
      .reg_bus   (reg_bus.ctrl)
   );

   config_regs u_config_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .reg_bus     (reg_bus.dev),
      .dout        (cfg_dout),
      .oe          (cfg_oe),
      .dev_options (dev_options)
   );

   coreid u_coreid (
      .clk     (clk),
      .rst_n   (rst_n),
      .reg_bus (reg_bus.dev),
      .dout    (id_dout),
      .oe      (id_oe)
   );

   kempston_joystick u_kempston (
      .clk    (clk),
      .rst_n  (rst_n),
      .a      (a),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .joy_n  (joy_n),
      .dout   (joy_dout),
      .oe     (joy_oe)
   );

   // CPU data-in bus
   io_read_select u_read_select (
      .addr_dout  (addr_dout),
      .addr_oe    (addr_oe),
      .joy_dout   (joy_dout),
      .joy_oe     (joy_oe),
      .cfg_dout   (cfg_dout),
      .cfg_oe     (cfg_oe),
      .id_dout    (id_dout),
      .id_oe      (id_oe),
      .dout       (dout),
      .dout_valid (dout_valid)
   );

endmodule

/* src/zxuno_reg_if.sv */
`timescale 1ns/10ps

// Register number, write data and access strobes of the ZX-Uno data port
interface zxuno_reg_if;
   zxio_pkg::zxreg_addr_t addr;
   zxio_pkg::io_data_t    wdata;
   logic                  regrd;
   logic                  regwr;
   logic                  regaddr_changed;

   modport ctrl (
      output addr,
      output wdata,
      output regrd,
      output regwr,
      output regaddr_changed
   );

   modport dev (
      input addr,
      input wdata,
      input regrd,
      input regwr,
      input regaddr_changed
   );
endinterface

/* src/zxuno_regs.sv */
`timescale 1ns/10ps

module zxuno_regs import zxio_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  io_addr_t a,
   input  logic     iorq_n,
   input  logic     rd_n,
   input  logic     wr_n,
   input  io_data_t din,
   output io_data_t addr_dout,
   output logic     addr_oe,
   zxuno_reg_if.ctrl reg_bus
);

   logic        addr_hit;
   logic        data_hit;
   logic        wr_cycle;
   logic        rd_cycle;
   logic        wr_cycle_q;
   logic        wr_start;
   zxreg_addr_t addr_q;
   logic        regwr_q;
   logic        changed_q;
   io_data_t    wdata_q;

   assign addr_hit = (a == ZXUNO_ADDR_PORT);
   assign data_hit = (a == ZXUNO_DATA_PORT);
   assign wr_cycle = !iorq_n && !wr_n;
   assign rd_cycle = !iorq_n && !rd_n;

   // First clock of a write cycle only
   assign wr_start = wr_cycle && !wr_cycle_q;

   // -------------------------------------------------------------------
   // Address register and write strobes
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_cycle_q <= 1'b0;
         addr_q     <= '0;
         regwr_q    <= 1'b0;
         changed_q  <= 1'b0;
      end else begin
         wr_cycle_q <= wr_cycle;
         regwr_q    <= wr_start && data_hit;
         changed_q  <= wr_start && addr_hit;
         if (wr_start && addr_hit) begin
            addr_q <= din;
         end
      end
   end

   // Data byte for the register write, sampled with the strobe
   always_ff @(posedge clk) begin
      if (wr_start && data_hit) begin
         wdata_q <= din;
      end
   end

   assign reg_bus.addr            = addr_q;
   assign reg_bus.wdata           = wdata_q;
   assign reg_bus.regwr           = regwr_q;
   assign reg_bus.regaddr_changed = changed_q;

   // Held for the whole read of the data port
   assign reg_bus.regrd = rd_cycle && data_hit;

   // Selected register number is readable at the address port
   assign addr_dout = addr_q;
   assign addr_oe   = rd_cycle && addr_hit;

endmodule
